// File: source/exe_pkg.sv
package exe_pkg;

  // operations carried from decode into execute
  typedef enum logic [4:0] {
    op_add,
    op_sub,
    op_slt,
    op_sltu,
    op_and,
    op_or,
    op_nor,
    op_xor,
    op_sll,
    op_srl,
    op_sra,
    op_lui,
    op_mul,
    op_mulh,
    op_mulhu,
    op_div,
    op_mod,
    op_divu,
    op_modu
  } alu_op_e;

  // decoded instruction entering execute
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] src1;
    logic [31:0] src2;
    alu_op_e     op;
    logic [31:0] store_data;
    logic        res_from_mem;
    logic        gr_we;
    logic [4:0]  dest;
    logic        mem_we;
  } ds2es_bus_t;

  // execute result heading to memory
  typedef struct packed {
    logic [31:0] pc;
    alu_op_e     op;
    logic [31:0] alu_result;
    logic        res_from_mem;
    logic        res_from_mul;
    logic        gr_we;
    logic [4:0]  dest;
  } es2ms_bus_t;

  // writeback leaving the memory stage
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] final_result;
    logic        gr_we;
    logic [4:0]  dest;
  } ms2ws_bus_t;

  // result comes from the multiplier
  function automatic logic is_mul_op(alu_op_e op);
    return (op == op_mul) || (op == op_mulh) || (op == op_mulhu);
  endfunction

  // result needs the multi-cycle divider
  function automatic logic is_div_op(alu_op_e op);
    return (op == op_div) || (op == op_mod) || (op == op_divu) || (op == op_modu);
  endfunction

endpackage

// File: source/alu.sv
`timescale 1ns/1ps

module alu (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  exe_pkg::alu_op_e op,
  input  logic [31:0]      src1,
  input  logic [31:0]      src2,
  output logic [31:0]      result,
  output logic             done
);
  import exe_pkg::*;

  logic [4:0]  shamt;
  logic [31:0] simple_result;
  logic        div_signed;
  logic        neg_quo;
  logic        neg_rem;
  logic [31:0] abs_a;
  logic [31:0] abs_b;
  logic        busy;
  logic [4:0]  div_cnt;
  logic [31:0] div_rem;
  logic [31:0] div_quo;
  logic [31:0] div_dvs;
  logic [32:0] trial;
  logic [33:0] diff;
  logic [31:0] quo_fixed;
  logic [31:0] rem_fixed;

  assign shamt = src2[4:0];

  always_comb begin
    case (op)
      op_add:  simple_result = src1 + src2;
      op_sub:  simple_result = src1 - src2;
      op_slt:  simple_result = {31'd0, $signed(src1) < $signed(src2)};
      op_sltu: simple_result = {31'd0, src1 < src2};
      op_and:  simple_result = src1 & src2;
      op_or:   simple_result = src1 | src2;
      op_nor:  simple_result = ~(src1 | src2);
      op_xor:  simple_result = src1 ^ src2;
      op_sll:  simple_result = src1 << shamt;
      op_srl:  simple_result = src1 >> shamt;
      op_sra:  simple_result = $unsigned($signed(src1) >>> shamt);
      op_lui:  simple_result = src2;
      default: simple_result = 32'd0;
    endcase
  end

  // sign handling for the divider, operands stay put in execute
  assign div_signed = (op == op_div) || (op == op_mod);
  assign neg_quo    = div_signed && (src1[31] ^ src2[31]);
  assign neg_rem    = div_signed && src1[31];
  assign abs_a      = (div_signed && src1[31]) ? -src1 : src1;
  assign abs_b      = (div_signed && src2[31]) ? -src2 : src2;

  // one restoring step
  assign trial = {div_rem, div_quo[31]};
  assign diff  = {1'b0, trial} - {2'b00, div_dvs};

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      div_cnt <= 5'd0;
    end else if (busy) begin
      div_cnt <= div_cnt + 5'd1;
      if (div_cnt == 5'd31) begin
        busy <= 1'b0;
      end
    end else if (start && is_div_op(op)) begin
      busy    <= 1'b1;
      div_cnt <= 5'd0;
    end
  end

  // datapath registers
  always_ff @(posedge clk) begin
    if (busy) begin
      if (!diff[33]) begin
        div_rem <= diff[31:0];
        div_quo <= {div_quo[30:0], 1'b1};
      end else begin
        div_rem <= trial[31:0];
        div_quo <= {div_quo[30:0], 1'b0};
      end
    end else if (start && is_div_op(op)) begin
      div_rem <= 32'd0;
      div_quo <= abs_a;
      div_dvs <= abs_b;
    end
  end

  // divide by zero overrides the raw magnitudes
  always_comb begin
    if (src2 == 32'd0) begin
      quo_fixed = 32'hffff_ffff;
      rem_fixed = src1;
    end else begin
      quo_fixed = neg_quo ? -div_quo : div_quo;
      rem_fixed = neg_rem ? -div_rem : div_rem;
    end
  end

  always_comb begin
    case (op)
      op_div, op_divu: result = quo_fixed;
      op_mod, op_modu: result = rem_fixed;
      default:         result = simple_result;
    endcase
  end

  assign done = !(busy || (start && is_div_op(op)));

  // a divide start must not hang the stage
  assert property (@(posedge clk) disable iff (reset)
    (start && is_div_op(op)) |-> ##[1:34] done);

endmodule

// File: source/mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
  input  logic             clk,
  input  logic             reset,
  input  logic             fire,
  input  exe_pkg::alu_op_e op,
  input  logic [31:0]      src1,
  input  logic [31:0]      src2,
  output logic [63:0]      product
);
  import exe_pkg::*;

  logic        ext_sign;
  logic [32:0] mul_a;
  logic [32:0] mul_b;
  logic [65:0] full_product;

  // mulhu zero-extends, the others sign-extend
  assign ext_sign = (op == op_mul) || (op == op_mulh);
  assign mul_a    = {ext_sign && src1[31], src1};
  assign mul_b    = {ext_sign && src2[31], src2};

  assign full_product = $signed(mul_a) * $signed(mul_b);

  // capture only for multiplies, hold for a stalled memory stage
  always_ff @(posedge clk) begin
    if (reset) begin
      product <= 64'd0;
    end else if (fire && is_mul_op(op)) begin
      product <= full_product[63:0];
    end
  end

endmodule

// File: source/exe_stage.sv
`timescale 1ns/1ps

module exe_stage #(
  parameter int ram_addr_width = 10
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      ds2es_valid,
  output logic                      es_allowin,
  input  exe_pkg::ds2es_bus_t       ds2es_bus,
  output logic                      es2ms_valid,
  input  logic                      ms_allowin,
  output exe_pkg::es2ms_bus_t       es2ms_bus,
  output logic                      mem_fire,
  output logic                      ram_we,
  output logic [ram_addr_width-1:0] ram_addr,
  output logic [31:0]               ram_wdata,
  output exe_pkg::alu_op_e          mul_op,
  output logic [31:0]               mul_src1,
  output logic [31:0]               mul_src2,
  output logic [4:0]                exe_dest,
  output logic                      exe_rf_we,
  output logic                      es_block
);
  import exe_pkg::*;

  logic        es_valid;
  ds2es_bus_t  es_inst;
  logic        div_start;
  logic        alu_done;
  logic [31:0] alu_result;
  logic        es2ms_fire;

  assign es_allowin  = !es_valid || (alu_done && ms_allowin);
  assign es2ms_valid = es_valid && alu_done;
  assign es2ms_fire  = es2ms_valid && ms_allowin;

  always_ff @(posedge clk) begin
    if (reset) begin
      es_valid  <= 1'b0;
      div_start <= 1'b0;
    end else begin
      if (es_allowin) begin
        es_valid <= ds2es_valid;
      end
      // single pulse on the cycle after a divide enters
      div_start <= ds2es_valid && es_allowin && is_div_op(ds2es_bus.op);
    end
  end

  always_ff @(posedge clk) begin
    if (ds2es_valid && es_allowin) begin
      es_inst <= ds2es_bus;
    end
  end

  alu alu_i (
    .clk    (clk),
    .reset  (reset),
    .start  (div_start),
    .op     (es_inst.op),
    .src1   (es_inst.src1),
    .src2   (es_inst.src2),
    .result (alu_result),
    .done   (alu_done)
  );

  assign es2ms_bus.pc           = es_inst.pc;
  assign es2ms_bus.op           = es_inst.op;
  assign es2ms_bus.alu_result   = alu_result;
  assign es2ms_bus.res_from_mem = es_inst.res_from_mem;
  assign es2ms_bus.res_from_mul = is_mul_op(es_inst.op);
  assign es2ms_bus.gr_we        = es_inst.gr_we;
  assign es2ms_bus.dest         = es_inst.dest;

  // ram access happens on the same edge the instruction moves on
  assign mem_fire  = es2ms_fire && (es_inst.res_from_mem || es_inst.mem_we);
  assign ram_we    = es_inst.mem_we;
  assign ram_addr  = alu_result[ram_addr_width+1:2];
  assign ram_wdata = es_inst.store_data;

  assign mul_op   = es_inst.op;
  assign mul_src1 = es_inst.src1;
  assign mul_src2 = es_inst.src2;

  // hazard info for decode
  assign exe_dest  = es_inst.dest;
  assign exe_rf_we = es_valid && es_inst.gr_we;
  assign es_block  = es_valid && es_inst.res_from_mem;

  assert property (@(posedge clk) disable iff (reset)
    es_valid |-> !(es_inst.res_from_mem && es_inst.mem_we));

endmodule

// File: source/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
  parameter int ram_addr_width = 10
) (
  input  logic                      clk,
  input  logic                      fire,
  input  logic                      we,
  input  logic [ram_addr_width-1:0] addr,
  input  logic [31:0]               wdata,
  output logic [31:0]               rdata
);

  logic [31:0] mem [0:(1 << ram_addr_width)-1];

  // whole-word writes, reads land one cycle later
  always_ff @(posedge clk) begin
    if (fire) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr];
      end
    end
  end

endmodule

// File: source/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
  input  logic                clk,
  input  logic                reset,
  input  logic                es2ms_valid,
  output logic                ms_allowin,
  input  exe_pkg::es2ms_bus_t es2ms_bus,
  input  logic [31:0]         ram_rdata,
  input  logic [63:0]         product,
  output logic                ms2ws_valid,
  input  logic                ws_allowin,
  output exe_pkg::ms2ws_bus_t ms2ws_bus
);
  import exe_pkg::*;

  logic        ms_valid;
  es2ms_bus_t  ms_inst;
  logic [31:0] final_result;

  // no wait states here
  assign ms_allowin  = !ms_valid || ws_allowin;
  assign ms2ws_valid = ms_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      ms_valid <= 1'b0;
    end else if (ms_allowin) begin
      ms_valid <= es2ms_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (es2ms_valid && ms_allowin) begin
      ms_inst <= es2ms_bus;
    end
  end

  always_comb begin
    if (ms_inst.res_from_mem) begin
      final_result = ram_rdata;
    end else if (ms_inst.res_from_mul) begin
      // mul wants the low half, mulh and mulhu the high half
      final_result = (ms_inst.op == op_mul) ? product[31:0] : product[63:32];
    end else begin
      final_result = ms_inst.alu_result;
    end
  end

  assign ms2ws_bus.pc           = ms_inst.pc;
  assign ms2ws_bus.final_result = final_result;
  assign ms2ws_bus.gr_we        = ms_inst.gr_we;
  assign ms2ws_bus.dest         = ms_inst.dest;

  // ram and multiplier must hold their values across the stall
  assert property (@(posedge clk) disable iff (reset)
    (ms2ws_valid && !ws_allowin) |=> $stable(ms2ws_bus));

endmodule

// File: source/exe_mem_top.sv
`timescale 1ns/1ps

module exe_mem_top #(
  parameter int ram_addr_width = 10
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                ds2es_valid,
  output logic                es_allowin,
  input  exe_pkg::ds2es_bus_t ds2es_bus,
  output logic                ms2ws_valid,
  input  logic                ws_allowin,
  output exe_pkg::ms2ws_bus_t ms2ws_bus,
  output logic [4:0]          exe_dest,
  output logic                exe_rf_we,
  output logic                es_block
);
  import exe_pkg::*;

  logic                      es2ms_valid;
  logic                      ms_allowin;
  es2ms_bus_t                es2ms_bus;
  logic                      mem_fire;
  logic                      ram_we;
  logic [ram_addr_width-1:0] ram_addr;
  logic [31:0]               ram_wdata;
  logic [31:0]               ram_rdata;
  alu_op_e                   mul_op;
  logic [31:0]               mul_src1;
  logic [31:0]               mul_src2;
  logic [63:0]               product;

  exe_stage #(
    .ram_addr_width (ram_addr_width)
  ) exe_stage_i (
    .clk         (clk),
    .reset       (reset),
    .ds2es_valid (ds2es_valid),
    .es_allowin  (es_allowin),
    .ds2es_bus   (ds2es_bus),
    .es2ms_valid (es2ms_valid),
    .ms_allowin  (ms_allowin),
    .es2ms_bus   (es2ms_bus),
    .mem_fire    (mem_fire),
    .ram_we      (ram_we),
    .ram_addr    (ram_addr),
    .ram_wdata   (ram_wdata),
    .mul_op      (mul_op),
    .mul_src1    (mul_src1),
    .mul_src2    (mul_src2),
    .exe_dest    (exe_dest),
    .exe_rf_we   (exe_rf_we),
    .es_block    (es_block)
  );

  // product captured on the execute to memory transfer
  mul_unit mul_unit_i (
    .clk     (clk),
    .reset   (reset),
    .fire    (es2ms_valid && ms_allowin),
    .op      (mul_op),
    .src1    (mul_src1),
    .src2    (mul_src2),
    .product (product)
  );

  data_ram #(
    .ram_addr_width (ram_addr_width)
  ) data_ram_i (
    .clk   (clk),
    .fire  (mem_fire),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

  mem_stage mem_stage_i (
    .clk         (clk),
    .reset       (reset),
    .es2ms_valid (es2ms_valid),
    .ms_allowin  (ms_allowin),
    .es2ms_bus   (es2ms_bus),
    .ram_rdata   (ram_rdata),
    .product     (product),
    .ms2ws_valid (ms2ws_valid),
    .ws_allowin  (ws_allowin),
    .ms2ws_bus   (ms2ws_bus)
  );

endmodule

// File: tb/exe_mem_tb.sv
`timescale 1ns/1ps

module exe_mem_tb;
  import exe_pkg::*;

  localparam int ram_addr_width = 10;
  localparam int kind_alu = 0;
  localparam int kind_mem = 1;
  localparam int kind_mul = 2;
  localparam int kind_div = 3;
  localparam int kind_mix = 4;
  localparam int total_insts = 200 + 160 + 120 + 60 + 200 + 200;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] value;
    logic        gr_we;
    logic [4:0]  dest;
    logic        check;
  } expect_t;

  logic       clk;
  logic       reset;
  logic       ds2es_valid;
  logic       es_allowin;
  ds2es_bus_t ds2es_bus;
  logic       ms2ws_valid;
  logic       ws_allowin;
  ms2ws_bus_t ms2ws_bus;
  logic [4:0] exe_dest;
  logic       exe_rf_we;
  logic       es_block;

  logic [31:0] rand_state;
  logic [31:0] stall_state;
  int          stall_level;
  int          error_count;
  int          test_count;
  int          inst_seq;

  // reference model, updated on falling edges only
  expect_t     exp_q[$];
  expect_t     exp_cur;
  expect_t     new_entry;
  logic        exp_have;
  logic        in_pend;
  logic        out_pend;
  logic        es_full;
  int          in_pipe;
  ds2es_bus_t  pend_inst;
  ds2es_bus_t  last_inst;
  logic [31:0] shadow [0:(1 << ram_addr_width)-1];
  bit          written [0:(1 << ram_addr_width)-1];
  logic [ram_addr_width-1:0] widx;

  exe_mem_top #(
    .ram_addr_width (ram_addr_width)
  ) exe_mem_top_i (
    .clk         (clk),
    .reset       (reset),
    .ds2es_valid (ds2es_valid),
    .es_allowin  (es_allowin),
    .ds2es_bus   (ds2es_bus),
    .ms2ws_valid (ms2ws_valid),
    .ws_allowin  (ws_allowin),
    .ms2ws_bus   (ms2ws_bus),
    .exe_dest    (exe_dest),
    .exe_rf_we   (exe_rf_we),
    .es_block    (es_block)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_next();
    rand_state = xorshift(rand_state);
    return rand_state;
  endfunction

  function automatic logic [31:0] expected_value(input alu_op_e op, input logic [31:0] a,
                                                 input logic [31:0] b);
    int                 sa;
    int                 sb;
    logic signed [63:0] sprod;
    logic [63:0]        uprod;
    logic               ovf;
    logic [31:0]        r;
    sa    = a;
    sb    = b;
    sprod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    uprod = {32'd0, a} * {32'd0, b};
    ovf   = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
      op_add:   r = a + b;
      op_sub:   r = a - b;
      op_slt:   r = (sa < sb) ? 32'd1 : 32'd0;
      op_sltu:  r = (a < b) ? 32'd1 : 32'd0;
      op_and:   r = a & b;
      op_or:    r = a | b;
      op_nor:   r = ~(a | b);
      op_xor:   r = a ^ b;
      op_sll:   r = a << b[4:0];
      op_srl:   r = a >> b[4:0];
      op_sra:   r = sa >>> b[4:0];
      op_lui:   r = b;
      op_mul:   r = sprod[31:0];
      op_mulh:  r = sprod[63:32];
      op_mulhu: r = uprod[63:32];
      op_div: begin
        if (b == 32'd0) begin
          r = 32'hffff_ffff;
        end else if (ovf) begin
          r = a;
        end else begin
          r = sa / sb;
        end
      end
      op_mod: begin
        if (b == 32'd0) begin
          r = a;
        end else if (ovf) begin
          r = 32'd0;
        end else begin
          r = sa % sb;
        end
      end
      op_divu: begin
        if (b == 32'd0) begin
          r = 32'hffff_ffff;
        end else begin
          r = a / b;
        end
      end
      op_modu: begin
        if (b == 32'd0) begin
          r = a;
        end else begin
          r = a % b;
        end
      end
      default:  r = 32'd0;
    endcase
    return r;
  endfunction

  function automatic ds2es_bus_t make_inst(input int kind);
    ds2es_bus_t  inst;
    logic [31:0] r;
    int          k;
    r = rand_next();
    k = kind;
    // mostly alu, then memory and multiply, few divides
    if (kind == kind_mix) begin
      case (r[2:0])
        3'd0, 3'd1, 3'd2: k = kind_alu;
        3'd3, 3'd4:       k = kind_mem;
        3'd5, 3'd6:       k = kind_mul;
        default:          k = kind_div;
      endcase
    end
    inst       = '0;
    inst.pc    = 32'h1c00_0000 + 32'(inst_seq) * 32'd4;
    inst.src1  = rand_next();
    inst.src2  = rand_next();
    inst.dest  = r[12:8];
    inst.gr_we = 1'b1;
    case (k)
      kind_alu: inst.op = alu_op_e'(5'(r[31:16] % 16'd12));
      kind_mul: inst.op = alu_op_e'(5'(16'd12 + r[31:16] % 16'd3));
      kind_mem: begin
        inst.op           = op_add;
        // sixteen words, so loads often hit an earlier store
        inst.src1         = {inst.src1[31:12], 12'd0};
        inst.src2         = {26'd0, r[19:16], 2'b00};
        inst.store_data   = rand_next();
        inst.mem_we       = r[20];
        inst.res_from_mem = !r[20];
        inst.gr_we        = !r[20];
      end
      default: begin
        inst.op = alu_op_e'(5'd15 + {3'd0, r[17:16]});
        case (r[21:19])
          3'd0: inst.src2 = 32'd0;
          3'd1: begin
            inst.src1 = 32'h8000_0000;
            inst.src2 = 32'hffff_ffff;
          end
          3'd2, 3'd3: inst.src2 = {{28{r[26]}}, r[25:22]};
          default: inst.src2 = inst.src2;
        endcase
      end
    endcase
    return inst;
  endfunction

  task automatic send_inst(input ds2es_bus_t inst);
    int gap;
    gap = 0;
    if (rand_next() % 32'd5 == 32'd0) begin
      gap = int'(rand_next() % 32'd3) + 1;
    end
    if (gap > 0) begin
      ds2es_valid <= 1'b0;
      repeat (gap) @(posedge clk);
    end
    ds2es_valid <= 1'b1;
    ds2es_bus   <= inst;
    // es_allowin has settled by the falling edge
    @(negedge clk);
    while (!es_allowin) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic run_test(input string name, input int kind, input int count, input int stalls);
    int err_before;
    int i;
    err_before  = error_count;
    stall_level = stalls;
    for (i = 0; i < count; i++) begin
      send_inst(make_inst(kind));
      inst_seq++;
    end
    ds2es_valid <= 1'b0;
    @(posedge clk);
    while (in_pipe != 0 || in_pend || out_pend) begin
      @(posedge clk);
    end
    test_count++;
    $display("test %0d %s: %0d instructions, %0d errors", test_count, name, count,
             error_count - err_before);
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ws_allowin stalls, stall_level out of 16
  always @(posedge clk) begin
    if (reset || stall_level == 0) begin
      ws_allowin <= 1'b1;
    end else begin
      stall_state = xorshift(stall_state);
      ws_allowin  <= (int'(stall_state[3:0]) >= stall_level);
    end
  end

  // commit last edge's transfers, then look ahead at the next edge
  always @(negedge clk) begin
    if (reset) begin
      exp_q.delete();
      in_pipe  = 0;
      in_pend  = 1'b0;
      out_pend = 1'b0;
      exp_have = 1'b0;
      es_full  = 1'b0;
    end else begin
      if (in_pend) begin
        in_pipe   = in_pipe + 1;
        last_inst = pend_inst;
      end
      if (out_pend) begin
        in_pipe = in_pipe - 1;
      end
      es_full  = (in_pipe > (ms2ws_valid ? 1 : 0));
      out_pend = ms2ws_valid && ws_allowin;
      exp_have = 1'b0;
      if (out_pend && exp_q.size() > 0) begin
        exp_cur  = exp_q.pop_front();
        exp_have = 1'b1;
      end
      in_pend = ds2es_valid && es_allowin;
      if (in_pend) begin
        pend_inst       = ds2es_bus;
        new_entry.pc    = ds2es_bus.pc;
        new_entry.gr_we = ds2es_bus.gr_we;
        new_entry.dest  = ds2es_bus.dest;
        new_entry.check = 1'b1;
        new_entry.value = expected_value(ds2es_bus.op, ds2es_bus.src1, ds2es_bus.src2);
        widx = new_entry.value[ram_addr_width+1:2];
        if (ds2es_bus.mem_we) begin
          shadow[widx]  = ds2es_bus.store_data;
          written[widx] = 1'b1;
        end else if (ds2es_bus.res_from_mem) begin
          new_entry.value = shadow[widx];
          new_entry.check = written[widx];
        end
        exp_q.push_back(new_entry);
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    (ms2ws_valid && ws_allowin) |-> exp_have)
    else begin
      error_count++;
      $display("unexpected writeback at %0t for pc %h", $time, ms2ws_bus.pc);
    end

  assert property (@(posedge clk) disable iff (reset)
    (ms2ws_valid && ws_allowin && exp_have) |->
      (ms2ws_bus.pc == exp_cur.pc) && (ms2ws_bus.gr_we == exp_cur.gr_we) &&
      (ms2ws_bus.dest == exp_cur.dest) &&
      (!exp_cur.check || ms2ws_bus.final_result == exp_cur.value))
    else begin
      error_count++;
      $display("Mismatch at %0t: pc %h result %h, expected pc %h result %h", $time,
               ms2ws_bus.pc, ms2ws_bus.final_result, exp_cur.pc, exp_cur.value);
    end

  assert property (@(posedge clk) disable iff (reset)
    (ms2ws_valid && !ws_allowin) |=> (ms2ws_valid && $stable(ms2ws_bus)))
    else begin
      error_count++;
      $display("Mismatch at %0t: writeback bus changed during a stall", $time);
    end

  // empty execute takes input, full execute behind a stalled memory stage does not
  assert property (@(posedge clk) disable iff (reset)
    (!es_full || (ms2ws_valid && !ws_allowin)) |-> (es_allowin == !es_full))
    else begin
      error_count++;
      $display("Mismatch at %0t: es_allowin %b, expected %b", $time, es_allowin, !es_full);
    end

  // hazard outputs follow the instruction held in execute
  assert property (@(posedge clk) disable iff (reset)
    es_full |-> (es_block == last_inst.res_from_mem) && (exe_rf_we == last_inst.gr_we) &&
                (exe_dest == last_inst.dest))
    else begin
      error_count++;
      $display("Mismatch at %0t: es_block %b exe_rf_we %b exe_dest %0d, expected %b %b %0d",
               $time, es_block, exe_rf_we, exe_dest, last_inst.res_from_mem,
               last_inst.gr_we, last_inst.dest);
    end

  assert property (@(posedge clk) disable iff (reset)
    !es_full |-> (!es_block && !exe_rf_we))
    else begin
      error_count++;
      $display("Mismatch at %0t: hazard flags set with execute empty", $time);
    end

  initial begin
    rand_state  = 32'h12ae_7908;
    stall_state = xorshift(32'h12ae_7908 ^ 32'hffff_0000);
    stall_level = 0;
    error_count = 0;
    test_count  = 0;
    inst_seq    = 0;
    reset       = 1'b1;
    ds2es_valid = 1'b0;
    ds2es_bus   = '0;
    ws_allowin  = 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    run_test("alu", kind_alu, 200, 0);
    run_test("load_store", kind_mem, 160, 0);
    run_test("multiply", kind_mul, 120, 6);
    run_test("divide", kind_div, 60, 4);
    run_test("stall", kind_mix, 200, 10);
    run_test("hazard", kind_mix, 200, 2);
    $display("%0d tests, %0d instructions, %0d errors", test_count, inst_seq, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // generous bound on the whole run
  initial begin
    #(longint'(total_insts) * 40 * 8 * 2 + 16 * 8);
    $display("watchdog expired at %0t with instructions still outstanding", $time);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: vlog.f
source/exe_pkg.sv
source/alu.sv
source/mul_unit.sv
source/exe_stage.sv
source/data_ram.sv
source/mem_stage.sv
source/exe_mem_top.sv
tb/exe_mem_tb.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module exe_mem_tb -f vlog.f -o exe_mem_sim

run: compile
	@out="$$(./obj_dir/exe_mem_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir
